/* verilog.f */
+incdir+hw
hw/a2mem_pkg.sv
hw/bus_capture.sv
hw/switch_tracker.sv
hw/shadow_writer.sv
hw/apple_memory.sv
testbench/tb_apple_memory.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the Apple II shadow memory testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_apple_memory \
    -Mdir obj_dir > "$LOG" 2>&1 \
    && ./obj_dir/Vtb_apple_memory >> "$LOG" 2>&1

grep -q "^TESTBENCH PASSED$" "$LOG" && echo "Run passed, log in $LOG" \
    || { echo "Run failed, see $LOG"; exit 1; }

/* testbench/golden_vectors.txt */
// stb rw_n m2sel_n m2b0 addr data | switches keycode keypress wr waddr wdata byte_en
// One line per clock; request columns only matter where wr is 1
0 1 0 0 0000 00  8100 00 0 0 000000 00000000 0
1 0 0 0 0400 41  8100 00 0 1 000200 41414141 1
1 0 0 0 2001 5A  8100 00 0 1 001000 5A5A5A5A 4
1 0 1 0 0600 11  8100 00 0 0 000000 00000000 0
1 0 0 0 6000 22  8100 00 0 0 000000 00000000 0
1 1 0 0 C050 00  0100 00 0 0 000000 00000000 0
1 1 0 0 C057 00  1100 00 0 0 000000 00000000 0
1 0 0 0 C001 00  1180 00 0 0 000000 00000000 0
1 0 0 0 C055 00  3180 00 0 0 000000 00000000 0
1 0 0 0 0401 33  3180 00 0 1 000200 33333333 8
1 0 0 0 3FFE 44  3180 00 0 1 001FFF 44444444 2
1 0 0 0 0800 55  3180 00 0 1 000400 55555555 1
1 0 0 0 C068 31  11F0 00 0 0 000000 00000000 0
1 0 0 0 2000 66  11F0 00 0 1 001000 66666666 1
1 0 0 0 0402 77  11F0 00 0 1 000201 77777777 1
1 0 0 0 4000 88  11F0 00 0 1 002000 88888888 2
1 0 0 0 C000 00  1170 00 0 0 000000 00000000 0
1 0 0 0 0403 99  1170 00 0 1 000201 99999999 8
1 0 0 0 C004 00  1150 00 0 0 000000 00000000 0
1 0 0 1 0BFE AA  1150 00 0 1 0005FF AAAAAAAA 2
1 1 0 0 C000 C1  1150 C1 1 0 000000 00000000 0
1 1 0 0 C000 C2  1150 C1 0 0 000000 00000000 0
1 1 0 0 C010 00  1150 41 0 0 000000 00000000 0
1 1 0 0 C000 C2  1150 C2 1 0 000000 00000000 0
0 1 0 0 0000 00  1150 C2 0 0 000000 00000000 0

/* testbench/tb_apple_memory.sv */
// Testbench for apple_memory: golden vector replay, result checks and watchdog

module tb_apple_memory
    import a2mem_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_CYCLES = 4;
    localparam int MAX_VECTORS  = 64;
    localparam int COLS         = 13;

    // Column positions in a vector line
    localparam int COL_STB   = 0;
    localparam int COL_RWN   = 1;
    localparam int COL_M2SN  = 2;
    localparam int COL_M2B0  = 3;
    localparam int COL_ADDR  = 4;
    localparam int COL_DATA  = 5;
    localparam int COL_SW    = 6;
    localparam int COL_KEY   = 7;
    localparam int COL_KP    = 8;
    localparam int COL_WR    = 9;
    localparam int COL_WADDR = 10;
    localparam int COL_WDATA = 11;
    localparam int COL_BE    = 12;

    logic     a2bus_if     = 1'b0;
    logic     reset_i      = 1'b1;
    logic     bus_strobe_i = 1'b0;
    logic     rw_n_i       = 1'b1;
    logic     m2sel_n_i    = 1'b1;
    logic     m2b0_i       = 1'b0;
    a2_addr_t addr_i       = '0;
    a2_data_t data_i       = '0;

    switch_state_t switches_o;
    a2_data_t      keycode_o;
    logic          keypress_strobe_o;
    shadow_req_t   shadow_req_o;
    logic          aux_mem_o;

    logic [31:0] golden [0:MAX_VECTORS*COLS-1];
    int          vec_count     = 0;
    logic        golden_loaded = 1'b0;
    int          cycle_count   = 0;
    int          replay_idx;
    int          error_count   = 0;
    int          check_count   = 0;

    // Vector index seen by each DUT stage, -1 when idle
    int drv_idx  = -1;
    int stg1_idx = -1;
    int stg2_idx = -1;
    int stg3_idx = -1;

    apple_memory apple_memory_inst (
        .a2bus_if          (a2bus_if),
        .reset_i           (reset_i),
        .bus_strobe_i      (bus_strobe_i),
        .rw_n_i            (rw_n_i),
        .m2sel_n_i         (m2sel_n_i),
        .m2b0_i            (m2b0_i),
        .addr_i            (addr_i),
        .data_i            (data_i),
        .switches_o        (switches_o),
        .keycode_o         (keycode_o),
        .keypress_strobe_o (keypress_strobe_o),
        .shadow_req_o      (shadow_req_o),
        .aux_mem_o         (aux_mem_o)
    );

    always #(CLK_PERIOD / 2) a2bus_if = ~a2bus_if;

    function automatic logic [31:0] vec_field(input int idx, input int col);
        return golden[idx * COLS + col];
    endfunction

    task automatic check_value(input string what, input int line,
                               input logic [31:0] got, input logic [31:0] expected);
        check_count++;
        assert (got == expected) else begin
            error_count++;
            $display("MISMATCH at time %0t: vector %0d %s is %h, expected %h",
                     $time, line, what, got, expected);
        end
    endtask

    // ------------------------------------------------------------------------
    // Reset and stimulus, one vector line per clock
    // ------------------------------------------------------------------------

    assign replay_idx = cycle_count - RESET_CYCLES;

    always @(posedge a2bus_if) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == RESET_CYCLES - 1) begin
            reset_i <= 1'b0;
        end
        if (replay_idx >= 0 && replay_idx < vec_count) begin
            bus_strobe_i <= vec_field(replay_idx, COL_STB) != 32'd0;
            rw_n_i       <= vec_field(replay_idx, COL_RWN) != 32'd0;
            m2sel_n_i    <= vec_field(replay_idx, COL_M2SN) != 32'd0;
            m2b0_i       <= vec_field(replay_idx, COL_M2B0) != 32'd0;
            addr_i       <= 16'(vec_field(replay_idx, COL_ADDR));
            data_i       <= 8'(vec_field(replay_idx, COL_DATA));
            drv_idx      <= replay_idx;
        end else begin
            bus_strobe_i <= 1'b0;
            drv_idx      <= -1;
        end
    end

    always @(posedge a2bus_if) begin
        stg1_idx <= drv_idx;
        stg2_idx <= stg1_idx;
        stg3_idx <= stg2_idx;
    end

    // Outputs are settled by the falling edge
    always @(negedge a2bus_if) begin
        if (stg2_idx >= 0) begin
            check_value("switches_o", stg2_idx, {16'h0, switches_o}, vec_field(stg2_idx, COL_SW));
            check_value("keycode_o", stg2_idx, {24'h0, keycode_o}, vec_field(stg2_idx, COL_KEY));
            check_value("keypress_strobe_o", stg2_idx, {31'h0, keypress_strobe_o},
                        vec_field(stg2_idx, COL_KP));
        end
        if (stg3_idx >= 0) begin
            check_value("shadow wr", stg3_idx, {31'h0, shadow_req_o.wr},
                        vec_field(stg3_idx, COL_WR));
            if (vec_field(stg3_idx, COL_WR) != 32'd0) begin
                check_value("shadow addr", stg3_idx, {11'h0, shadow_req_o.addr},
                            vec_field(stg3_idx, COL_WADDR));
                check_value("shadow data", stg3_idx, shadow_req_o.data,
                            vec_field(stg3_idx, COL_WDATA));
                check_value("shadow byte_en", stg3_idx, {28'h0, shadow_req_o.byte_en},
                            vec_field(stg3_idx, COL_BE));
                // Odd lanes mean the auxiliary bank unless m2b0 forced the lane
                if (vec_field(stg3_idx, COL_M2B0) == 32'd0) begin
                    check_value("aux_mem_o", stg3_idx, {31'h0, aux_mem_o},
                                {31'h0, |(vec_field(stg3_idx, COL_BE) & 32'hA)});
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Vector load, run control and summary
    // ------------------------------------------------------------------------

    initial begin
        // Unused slots carry their own address so a short file stays visible
        for (int i = 0; i < MAX_VECTORS * COLS; i++) begin
            golden[i] = 32'hEEEE_0000 | 32'(i);
        end
        $readmemh("testbench/golden_vectors.txt", golden);
        while (vec_count < MAX_VECTORS && golden[vec_count * COLS] <= 32'd1) begin
            vec_count++;
        end
        golden_loaded = 1'b1;
        if (vec_count == 0) begin
            error_count++;
            $display("No vectors could be read from testbench/golden_vectors.txt");
        end
        while (cycle_count < RESET_CYCLES + vec_count + DRAIN_CYCLES) begin
            @(posedge a2bus_if);
        end
        $display("Summary: %0d vectors, %0d checks, %0d errors",
                 vec_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        wait (golden_loaded);
        #(vec_count * CLK_PERIOD + 400);
        $display("Watchdog expired before the vector replay finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* hw/apple_memory.sv */
// Top level: bus capture, switch tracking and shadow write stages in a chain

module apple_memory
    import a2mem_pkg::*;
(
    input  logic          a2bus_if,
    input  logic          reset_i,

    // Apple II bus
    input  logic          bus_strobe_i,
    input  logic          rw_n_i,
    input  logic          m2sel_n_i,
    input  logic          m2b0_i,
    input  a2_addr_t      addr_i,
    input  a2_data_t      data_i,

    // Machine state
    output switch_state_t switches_o,
    output a2_data_t      keycode_o,
    output logic          keypress_strobe_o,

    // SDRAM shadow port
    output shadow_req_t   shadow_req_o,
    output logic          aux_mem_o
);

    bus_cycle_t captured_cycle;
    bus_cycle_t tracked_cycle;

    bus_capture bus_capture_inst (
        .a2bus_if     (a2bus_if),
        .reset_i      (reset_i),
        .bus_strobe_i (bus_strobe_i),
        .rw_n_i       (rw_n_i),
        .m2sel_n_i    (m2sel_n_i),
        .m2b0_i       (m2b0_i),
        .addr_i       (addr_i),
        .data_i       (data_i),
        .cycle_o      (captured_cycle)
    );

    switch_tracker switch_tracker_inst (
        .a2bus_if          (a2bus_if),
        .reset_i           (reset_i),
        .cycle_i           (captured_cycle),
        .cycle_o           (tracked_cycle),
        .switches_o        (switches_o),
        .keycode_o         (keycode_o),
        .keypress_strobe_o (keypress_strobe_o)
    );

    shadow_writer shadow_writer_inst (
        .a2bus_if     (a2bus_if),
        .reset_i      (reset_i),
        .cycle_i      (tracked_cycle),
        .switches_i   (switches_o),
        .shadow_req_o (shadow_req_o),
        .aux_mem_o    (aux_mem_o)
    );

endmodule

/* hw/shadow_writer.sv */
// Third stage: bank selection and the registered SDRAM shadow write request

module shadow_writer
    import a2mem_pkg::*;
(
    input  logic          a2bus_if,
    input  logic          reset_i,
    input  bus_cycle_t    cycle_i,
    input  switch_state_t switches_i,
    output shadow_req_t   shadow_req_o,
    output logic          aux_mem_o
);

    // switches_i already holds the update of the cycle now at cycle_i,
    // one more stage of delay gives the state the CPU saw at that cycle
    switch_state_t sw_q;

    logic      bank;
    logic      req_fire;
    logic      req_wr_q;
    logic      aux_q;
    mem_addr_t req_addr_q;
    mem_word_t req_data_q;
    byte_en_t  req_be_q;

    always_ff @(posedge a2bus_if) begin
        sw_q <= switches_i;
    end

    // ----------------------------------------------------------------------
    // Main / auxiliary bank select
    // ----------------------------------------------------------------------

    always_comb begin
        if (cycle_i.zp_or_rom) begin
            bank = sw_q.altzp;
        end else if (cycle_i.text_page) begin
            bank = (sw_q.store80 & sw_q.page2) | (~sw_q.store80 & sw_q.ramwrt);
        end else if (cycle_i.hires_page) begin
            bank = (sw_q.store80 & sw_q.page2 & sw_q.hires_mode) |
                   ((~sw_q.store80 | ~sw_q.hires_mode) & sw_q.ramwrt);
        end else begin
            bank = sw_q.ramwrt;
        end
    end

    assign req_fire = cycle_i.valid && cycle_i.write && cycle_i.m2sel && cycle_i.shadow_range;

    always_ff @(posedge a2bus_if) begin
        if (reset_i) begin
            req_wr_q <= 1'b0;
            aux_q    <= 1'b0;
        end else begin
            req_wr_q <= req_fire;
            if (req_fire) begin
                aux_q <= bank;
            end
        end
    end

    // Word holds two bytes per bank, lane = {addr[0], aux}
    always_ff @(posedge a2bus_if) begin
        if (req_fire) begin
            req_addr_q <= mem_addr_t'(cycle_i.addr[15:1]);
            req_data_q <= {4{cycle_i.data}};
            req_be_q   <= byte_en_t'(4'b0001 << {cycle_i.addr[0], bank | cycle_i.m2b0});
        end
    end

    assign shadow_req_o = '{
        wr:      req_wr_q,
        addr:    req_addr_q,
        data:    req_data_q,
        byte_en: req_be_q
    };

    assign aux_mem_o = aux_q;

    a_one_lane: assert property (
        @(posedge a2bus_if) disable iff (reset_i)
        shadow_req_o.wr |-> $onehot(shadow_req_o.byte_en)
    );

endmodule

/* hw/switch_tracker.sv */
// Second stage: soft switch registers, keyboard latch and cycle forwarding

`include "a2mem_settings.svh"

module switch_tracker
    import a2mem_pkg::*;
(
    input  logic          a2bus_if,
    input  logic          reset_i,
    input  bus_cycle_t    cycle_i,
    output bus_cycle_t    cycle_o,
    output switch_state_t switches_o,
    output a2_data_t      keycode_o,
    output logic          keypress_strobe_o
);

    // Indexed by address bits 3:1, as on the real machine
    logic [7:0] sw_ii;
    logic [7:0] sw_iie;

    a2_data_t   keycode_q;
    logic       key_strobe_q;
    bus_cycle_t cycle_q;
    logic       valid_q;

    logic sw_cycle;
    logic hit_c05;
    logic hit_c00_wr;
    logic hit_state_wr;
    logic kbd_read;
    logic kbd_clear;

    // Switch decode only looks at motherboard cycles
    assign sw_cycle     = cycle_i.valid && cycle_i.m2sel;
    assign hit_c05      = cycle_i.addr[15:4] == `A2_PAGE_C05;
    assign hit_c00_wr   = cycle_i.write && (cycle_i.addr[15:4] == `A2_PAGE_C00);
    assign hit_state_wr = cycle_i.write && (cycle_i.addr == `A2_ADDR_STATEREG);

    assign kbd_read  = cycle_i.valid && !cycle_i.write && (cycle_i.addr == `A2_ADDR_KBD);
    assign kbd_clear = cycle_i.valid && (cycle_i.addr == `A2_ADDR_KBDSTRB);

    // ----------------------------------------------------------------------
    // Soft switches
    // ----------------------------------------------------------------------

    always_ff @(posedge a2bus_if) begin
        if (reset_i) begin
            // TEXT_MODE and AN3 come up set
            sw_ii  <= 8'b1000_0001;
            sw_iie <= 8'b0000_0000;
        end else if (sw_cycle) begin
            if (hit_c05) begin
                sw_ii[cycle_i.addr[3:1]] <= cycle_i.addr[0];
            end else if (hit_c00_wr) begin
                sw_iie[cycle_i.addr[3:1]] <= cycle_i.addr[0];
            end else if (hit_state_wr) begin
                // IIgs state register mirrors
                sw_ii[2]  <= cycle_i.data[6];
                sw_iie[1] <= cycle_i.data[5];
                sw_iie[2] <= cycle_i.data[4];
                sw_iie[3] <= cycle_i.data[0];
            end
        end
    end

    // ----------------------------------------------------------------------
    // Keyboard latch
    // ----------------------------------------------------------------------

    always_ff @(posedge a2bus_if) begin
        if (reset_i) begin
            keycode_q    <= '0;
            key_strobe_q <= 1'b0;
        end else begin
            key_strobe_q <= 1'b0;
            if (kbd_read && cycle_i.data[7] && !keycode_q[7]) begin
                keycode_q    <= cycle_i.data;
                key_strobe_q <= 1'b1;
            end else if (kbd_clear) begin
                keycode_q[7] <= 1'b0;
            end
        end
    end

    // Delay the cycle by one stage
    always_ff @(posedge a2bus_if) begin
        cycle_q <= cycle_i;
    end

    always_ff @(posedge a2bus_if) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cycle_i.valid;
        end
    end

    always_comb begin
        cycle_o       = cycle_q;
        cycle_o.valid = valid_q;
    end

    always_comb begin
        switches_o.text_mode  = sw_ii[0];
        switches_o.mixed_mode = sw_ii[1];
        switches_o.page2      = sw_ii[2];
        switches_o.hires_mode = sw_ii[3];
        switches_o.an0        = sw_ii[4];
        switches_o.an1        = sw_ii[5];
        switches_o.an2        = sw_ii[6];
        switches_o.an3        = sw_ii[7];
        switches_o.store80    = sw_iie[0];
        switches_o.ramrd      = sw_iie[1];
        switches_o.ramwrt     = sw_iie[2];
        switches_o.intcxrom   = sw_iie[3];
        switches_o.altzp      = sw_iie[4];
        switches_o.slotc3rom  = sw_iie[5];
        switches_o.col80      = sw_iie[6];
        switches_o.altchar    = sw_iie[7];
    end

    assign keycode_o         = keycode_q;
    assign keypress_strobe_o = key_strobe_q;

    // Latched bit 7 blocks a second key until C010 is touched
    a_single_keypress: assert property (
        @(posedge a2bus_if) disable iff (reset_i)
        keypress_strobe_o |=> !keypress_strobe_o
    );

endmodule

/* hw/bus_capture.sv */
// First stage: registers a strobed bus cycle and classifies its address

`include "a2mem_settings.svh"

module bus_capture
    import a2mem_pkg::*;
(
    input  logic       a2bus_if,
    input  logic       reset_i,
    input  logic       bus_strobe_i,
    input  logic       rw_n_i,
    input  logic       m2sel_n_i,
    input  logic       m2b0_i,
    input  a2_addr_t   addr_i,
    input  a2_data_t   data_i,
    output bus_cycle_t cycle_o
);

    bus_cycle_t cycle_d;
    bus_cycle_t cycle_q;
    logic       valid_q;
    logic       in_text;
    logic       in_hires;

    // Shadow windows from the settings header
    assign in_text  = (addr_i >= `A2_TEXT_LO) && (addr_i <= `A2_TEXT_HI);
    assign in_hires = (addr_i >= `A2_HIRES_LO) && (addr_i <= `A2_HIRES_HI);

    always_comb begin
        cycle_d              = '0;
        cycle_d.valid        = bus_strobe_i;
        cycle_d.write        = !rw_n_i;
        cycle_d.m2sel        = !m2sel_n_i;
        cycle_d.m2b0         = m2b0_i;
        cycle_d.addr         = addr_i;
        cycle_d.data         = data_i;
        cycle_d.zp_or_rom    = (addr_i[15:9] == 7'b0000000) || (addr_i[15:14] == 2'b11);
        cycle_d.text_page    = (addr_i[15:10] == 6'b000001);
        cycle_d.hires_page   = (addr_i[15:13] == 3'b001);
        cycle_d.shadow_range = `A2_SHADOW_ALL || in_text || in_hires;
    end

    // Payload is only captured on a strobe
    always_ff @(posedge a2bus_if) begin
        if (bus_strobe_i) begin
            cycle_q <= cycle_d;
        end
    end

    always_ff @(posedge a2bus_if) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= bus_strobe_i;
        end
    end

    always_comb begin
        cycle_o       = cycle_q;
        cycle_o.valid = valid_q;
    end

    // A valid cycle needs a fresh strobe behind it
    a_valid_needs_strobe: assert property (
        @(posedge a2bus_if) disable iff (reset_i)
        (cycle_o.valid && !bus_strobe_i) |=> !cycle_o.valid
    );

endmodule

/* hw/a2mem_pkg.sv */
// Width typedefs and the packed structs passed between the shadow stages

package a2mem_pkg;

    // Apple II bus
    typedef logic [15:0] a2_addr_t;
    typedef logic [7:0]  a2_data_t;

    // SDRAM write port
    typedef logic [31:0] mem_word_t;
    typedef logic [20:0] mem_addr_t;
    typedef logic [3:0]  byte_en_t;

    // One bus cycle with its address class already decoded
    typedef struct packed {
        logic     valid;
        logic     write;
        logic     m2sel;        // High when the bus m2sel_n line was low
        logic     m2b0;
        a2_addr_t addr;
        a2_data_t data;
        logic     zp_or_rom;    // Pages 00-01 and C0-FF
        logic     text_page;    // Pages 04-07
        logic     hires_page;   // Pages 20-3F
        logic     shadow_range;
    } bus_cycle_t;

    // ][ switches first, then the //e switches
    typedef struct packed {
        logic text_mode;
        logic mixed_mode;
        logic page2;
        logic hires_mode;
        logic an0;
        logic an1;
        logic an2;
        logic an3;
        logic store80;
        logic ramrd;
        logic ramwrt;
        logic intcxrom;
        logic altzp;
        logic slotc3rom;
        logic col80;
        logic altchar;
    } switch_state_t;

    typedef struct packed {
        logic      wr;
        mem_addr_t addr;
        mem_word_t data;
        byte_en_t  byte_en;
    } shadow_req_t;

endpackage

/* hw/a2mem_settings.svh */
// Soft switch addresses, shadow address ranges and the shadow-all option

`ifndef A2MEM_SETTINGS_SVH
`define A2MEM_SETTINGS_SVH

// --------------------------------------------------------------------------
// Shadow policy
// --------------------------------------------------------------------------

// 1 shadows every bus write, 0 shadows only the video areas below
`define A2_SHADOW_ALL       1'b0

// Text and lores pages 1 and 2
`define A2_TEXT_LO          16'h0400
`define A2_TEXT_HI          16'h0BFF

// Hires pages 1 and 2
`define A2_HIRES_LO         16'h2000
`define A2_HIRES_HI         16'h5FFF

// --------------------------------------------------------------------------
// Soft switch decode
// --------------------------------------------------------------------------

// Page prefixes, compared against address bits 15:4
`define A2_PAGE_C00         12'hC00
`define A2_PAGE_C05         12'hC05

// Single addresses
`define A2_ADDR_STATEREG    16'hC068
`define A2_ADDR_KBD         16'hC000
`define A2_ADDR_KBDSTRB     16'hC010

`endif
